// File: files.f
+incdir+source
source/ucodePkg.sv
source/opcodeMap.sv
source/ucodeRom.sv
source/ucodeSequencer.sv
source/ucodeControl.sv
tests/ucodeControl_chk.sv
tests/ucodeControlTb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, pass only when the pass message is printed
verilator --binary --timing --assert -f files.f --top-module ucodeControlTb \
	--Mdir obj_dir -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "^No errors$" && exit 0 || exit 1

// File: source/opcodeMap.sv
`timescale 1ns/1ps
`include "ucodeControl_cfg.svh"

module opcodeMap
(
	input  logic                    useCb,
	input  logic [`UC_OPCODE_W-1:0] opcode,
	output logic [`UC_MPC_W-1:0]    entryPc
);
	import ucodePkg::*;

	logic [`UC_MPC_W-1:0] mainEntry;
	logic [`UC_MPC_W-1:0] cbEntry;

	// Main opcode table
	always_comb
	begin
		case (opcode)
			opNop:      mainEntry = `UC_ENTRY_NOP;
			opLdBn:     mainEntry = `UC_ENTRY_LDB;
			opLdCn:     mainEntry = `UC_ENTRY_LDC;
			opLdAn:     mainEntry = `UC_ENTRY_LDA;
			opJr:       mainEntry = `UC_ENTRY_JR;
			opJrNz:     mainEntry = `UC_ENTRY_JRNZ;
			opJrZ:      mainEntry = `UC_ENTRY_JRZ;
			opAddB:     mainEntry = `UC_ENTRY_ADDB;
			opSubB:     mainEntry = `UC_ENTRY_SUBB;
			opPopBc:    mainEntry = `UC_ENTRY_POPBC;
			opPushBc:   mainEntry = `UC_ENTRY_PUSHBC;
			opPrefixCb: mainEntry = `UC_ENTRY_CB;
			default:    mainEntry = `UC_ENTRY_ALU1;
		endcase
	end

	// CB table, unknown bytes fall back to NOP
	always_comb
	begin
		case (opcode)
			cbBit7H: cbEntry = `UC_ENTRY_BIT7H;
			cbRlC:   cbEntry = `UC_ENTRY_RLC;
			default: cbEntry = `UC_ENTRY_NOP;
		endcase
	end

	assign entryPc = useCb ? cbEntry : mainEntry;

endmodule

// File: source/ucodeControl.sv
`timescale 1ns/1ps
`include "ucodeControl_cfg.svh"

module ucodeControl
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    opValid,
	input  logic [`UC_OPCODE_W-1:0] opcode,
	input  logic                    zeroFlag,
	output logic                    uopValid,
	output ucodePkg::uop_t          uop,
	output logic                    pcInc,
	output logic                    busy,
	output logic                    flowDone
);
	import ucodePkg::*;

	logic                    useCb;
	logic [`UC_OPCODE_W-1:0] mapOpcode;
	logic [`UC_MPC_W-1:0]    entryPc;
	logic [`UC_MPC_W-1:0]    romAddr;
	uop_t                    romWord;

	ucodeSequencer seq0
	(
		.clock(clock),
		.rst(rst),
		.opValid(opValid),
		.opcode(opcode),
		.zeroFlag(zeroFlag),
		.useCb(useCb),
		.mapOpcode(mapOpcode),
		.entryPc(entryPc),
		.romAddr(romAddr),
		.romWord(romWord),
		.uopValid(uopValid),
		.uop(uop),
		.pcInc(pcInc),
		.busy(busy),
		.flowDone(flowDone)
	);

	opcodeMap map0
	(
		.useCb(useCb),
		.opcode(mapOpcode),
		.entryPc(entryPc)
	);

	ucodeRom rom0
	(
		.romAddr(romAddr),
		.romWord(romWord)
	);

endmodule

// File: source/ucodeControl_cfg.svh
`ifndef UCODE_CONTROL_CFG_SVH
`define UCODE_CONTROL_CFG_SVH

// Bus widths
`define UC_OPCODE_W 8
`define UC_MPC_W 6

// Populated words in the microcode ROM
`define UC_ROM_DEPTH 53

// Flow entry points in ROM order
`define UC_ENTRY_NOP 6'd0
`define UC_ENTRY_LDB 6'd1
`define UC_ENTRY_LDC 6'd4
`define UC_ENTRY_LDA 6'd7
`define UC_ENTRY_JR 6'd10
`define UC_ENTRY_JRNZ 6'd16
`define UC_ENTRY_JRZ 6'd22
`define UC_ENTRY_ADDB 6'd28
`define UC_ENTRY_SUBB 6'd31
`define UC_ENTRY_PUSHBC 6'd34
`define UC_ENTRY_POPBC 6'd40
`define UC_ENTRY_CB 6'd46
`define UC_ENTRY_BIT7H 6'd49
`define UC_ENTRY_RLC 6'd50
`define UC_ENTRY_ALU1 6'd51

`endif

// File: source/ucodePkg.sv
`include "ucodeControl_cfg.svh"

package ucodePkg;

	// What the sequencer does once a micro-op has been presented
	typedef enum logic [2:0]
	{
		step,
		stepIncPc,
		endFlow,
		endIncPc,
		endIfZero,
		endIfNotZero,
		fetchCb
	} seqAction_e;

	// Datapath operations
	typedef enum logic [3:0]
	{
		nop,
		setMemAddr,
		readMem,
		writeMem,
		loadX16,
		storeX16,
		addX16,
		subX16,
		inc16,
		dec16,
		setPc,
		bitTest,
		rotLeft,
		aluOneByte
	} microOp_e;

	// Register or source selector
	typedef enum logic [3:0]
	{
		none,
		a,
		b,
		c,
		h,
		pc,
		sp,
		x8,
		x16
	} operand_e;

	typedef struct packed
	{
		seqAction_e action;
		microOp_e   op;
		operand_e   operand;
	} uop_t;

	typedef enum logic [1:0]
	{
		idle,
		run,
		waitCb
	} seqState_e;

	////////////////////////////////////////////////////////////////////
	// Opcodes that own a flow
	typedef enum logic [`UC_OPCODE_W-1:0]
	{
		opNop      = 8'h00,
		opLdBn     = 8'h06,
		opLdCn     = 8'h0E,
		opJr       = 8'h18,
		opJrNz     = 8'h20,
		opJrZ      = 8'h28,
		opLdAn     = 8'h3E,
		opAddB     = 8'h80,
		opSubB     = 8'h90,
		opPopBc    = 8'hC1,
		opPushBc   = 8'hC5,
		opPrefixCb = 8'hCB
	} mainOpcode_e;

	// Second byte after the CB prefix
	typedef enum logic [`UC_OPCODE_W-1:0]
	{
		cbRlC   = 8'h11,
		cbBit7H = 8'h7C
	} cbOpcode_e;

endpackage

// File: source/ucodeRom.sv
`timescale 1ns/1ps
`include "ucodeControl_cfg.svh"

module ucodeRom
(
	input  logic [`UC_MPC_W-1:0] romAddr,
	output ucodePkg::uop_t       romWord
);
	import ucodePkg::*;

	localparam uop_t blankWord = '{endFlow, nop, none};

	always_comb
	begin
		romWord = blankWord;
		if (romAddr < `UC_ROM_DEPTH)
		begin
			case (romAddr)
				// NOP
				`UC_ENTRY_NOP:           romWord = '{endIncPc, nop, none};

				// Load immediate into B, C and A
				`UC_ENTRY_LDB:           romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_LDB + 6'd1:    romWord = '{stepIncPc, nop, none};
				`UC_ENTRY_LDB + 6'd2:    romWord = '{endFlow, readMem, b};
				`UC_ENTRY_LDC:           romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_LDC + 6'd1:    romWord = '{stepIncPc, nop, none};
				`UC_ENTRY_LDC + 6'd2:    romWord = '{endFlow, readMem, c};
				`UC_ENTRY_LDA:           romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_LDA + 6'd1:    romWord = '{stepIncPc, nop, none};
				`UC_ENTRY_LDA + 6'd2:    romWord = '{endFlow, readMem, a};

				////////////////////////////////////////////////////////////////////
				// Relative jumps, x16 = pc + sign-extended x8
				`UC_ENTRY_JR:            romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_JR + 6'd1:     romWord = '{step, nop, none};
				`UC_ENTRY_JR + 6'd2:     romWord = '{stepIncPc, readMem, x8};
				`UC_ENTRY_JR + 6'd3:     romWord = '{step, loadX16, pc};
				`UC_ENTRY_JR + 6'd4:     romWord = '{step, addX16, x8};
				`UC_ENTRY_JR + 6'd5:     romWord = '{endFlow, setPc, x16};

				// Jump taken only when Z is clear
				`UC_ENTRY_JRNZ:          romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_JRNZ + 6'd1:   romWord = '{step, nop, none};
				`UC_ENTRY_JRNZ + 6'd2:   romWord = '{endIfZero, readMem, x8};
				`UC_ENTRY_JRNZ + 6'd3:   romWord = '{step, loadX16, pc};
				`UC_ENTRY_JRNZ + 6'd4:   romWord = '{step, addX16, x8};
				`UC_ENTRY_JRNZ + 6'd5:   romWord = '{endFlow, setPc, x16};

				// Jump taken only when Z is set
				`UC_ENTRY_JRZ:           romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_JRZ + 6'd1:    romWord = '{step, nop, none};
				`UC_ENTRY_JRZ + 6'd2:    romWord = '{endIfNotZero, readMem, x8};
				`UC_ENTRY_JRZ + 6'd3:    romWord = '{step, loadX16, pc};
				`UC_ENTRY_JRZ + 6'd4:    romWord = '{step, addX16, x8};
				`UC_ENTRY_JRZ + 6'd5:    romWord = '{endFlow, setPc, x16};

				////////////////////////////////////////////////////////////////////
				// Accumulator arithmetic through x16
				`UC_ENTRY_ADDB:          romWord = '{step, loadX16, a};
				`UC_ENTRY_ADDB + 6'd1:   romWord = '{step, addX16, b};
				`UC_ENTRY_ADDB + 6'd2:   romWord = '{endIncPc, storeX16, a};
				`UC_ENTRY_SUBB:          romWord = '{step, loadX16, a};
				`UC_ENTRY_SUBB + 6'd1:   romWord = '{step, subX16, b};
				`UC_ENTRY_SUBB + 6'd2:   romWord = '{endIncPc, storeX16, a};

				// Stack, B goes to the higher address
				`UC_ENTRY_PUSHBC:        romWord = '{step, dec16, sp};
				`UC_ENTRY_PUSHBC + 6'd1: romWord = '{step, setMemAddr, sp};
				`UC_ENTRY_PUSHBC + 6'd2: romWord = '{step, writeMem, b};
				`UC_ENTRY_PUSHBC + 6'd3: romWord = '{step, dec16, sp};
				`UC_ENTRY_PUSHBC + 6'd4: romWord = '{step, writeMem, c};
				`UC_ENTRY_PUSHBC + 6'd5: romWord = '{endIncPc, setMemAddr, pc};
				`UC_ENTRY_POPBC:         romWord = '{step, setMemAddr, sp};
				`UC_ENTRY_POPBC + 6'd1:  romWord = '{step, inc16, sp};
				`UC_ENTRY_POPBC + 6'd2:  romWord = '{step, readMem, c};
				`UC_ENTRY_POPBC + 6'd3:  romWord = '{step, readMem, b};
				`UC_ENTRY_POPBC + 6'd4:  romWord = '{stepIncPc, inc16, sp};
				`UC_ENTRY_POPBC + 6'd5:  romWord = '{endFlow, setMemAddr, pc};

				// CB prefix then hand over to the CB map
				`UC_ENTRY_CB:            romWord = '{stepIncPc, setMemAddr, pc};
				`UC_ENTRY_CB + 6'd1:     romWord = '{step, nop, none};
				`UC_ENTRY_CB + 6'd2:     romWord = '{fetchCb, nop, none};
				`UC_ENTRY_BIT7H:         romWord = '{endIncPc, bitTest, h};
				`UC_ENTRY_RLC:           romWord = '{endIncPc, rotLeft, c};

				// Anything unmapped runs as a plain ALU op on A
				`UC_ENTRY_ALU1:          romWord = '{step, aluOneByte, a};
				`UC_ENTRY_ALU1 + 6'd1:   romWord = '{endIncPc, nop, none};
				default:                 romWord = blankWord;
			endcase
		end
	end

endmodule

// File: source/ucodeSequencer.sv
`timescale 1ns/1ps
`include "ucodeControl_cfg.svh"

module ucodeSequencer
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    opValid,
	input  logic [`UC_OPCODE_W-1:0] opcode,
	input  logic                    zeroFlag,
	output logic                    useCb,
	output logic [`UC_OPCODE_W-1:0] mapOpcode,
	input  logic [`UC_MPC_W-1:0]    entryPc,
	output logic [`UC_MPC_W-1:0]    romAddr,
	input  ucodePkg::uop_t          romWord,
	output logic                    uopValid,
	output ucodePkg::uop_t          uop,
	output logic                    pcInc,
	output logic                    busy,
	output logic                    flowDone
);
	import ucodePkg::*;

	seqState_e            state;
	seqState_e            stateNext;
	logic [`UC_MPC_W-1:0] mpc;
	logic                 fetch;
	logic                 lastWord;
	logic                 advancePc;

	assign useCb = (state == waitCb);
	assign mapOpcode = opcode;

	// Strobes only count outside a running flow
	assign fetch = (state == run) || (opValid && (state == idle || state == waitCb));

	// Entry point on launch, micro-PC while walking
	assign romAddr = (state == run) ? mpc : entryPc;

	////////////////////////////////////////////////////////////////////
	// Action decode of the word about to be presented
	always_comb
	begin
		lastWord = 1'b0;
		advancePc = 1'b0;
		case (romWord.action)
			stepIncPc:
				advancePc = 1'b1;
			endFlow:
				lastWord = 1'b1;
			endIncPc:
			begin
				lastWord = 1'b1;
				advancePc = 1'b1;
			end
			endIfZero:
				lastWord = zeroFlag;
			endIfNotZero:
				lastWord = !zeroFlag;
			default:
				lastWord = 1'b0;
		endcase
	end

	always_comb
	begin
		stateNext = state;
		if (fetch)
		begin
			if (lastWord)
				stateNext = idle;
			else if (romWord.action == fetchCb)
				stateNext = waitCb;
			else
				stateNext = run;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Control state and output strobes
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= idle;
			mpc <= '0;
			uopValid <= 1'b0;
			pcInc <= 1'b0;
			busy <= 1'b0;
			flowDone <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			uopValid <= fetch;
			pcInc <= fetch && advancePc;
			flowDone <= fetch && lastWord;
			// Still busy while the CB byte is pending
			busy <= fetch || (stateNext == waitCb);
			if (fetch)
				mpc <= romAddr + 6'd1;
		end
	end

	// Micro-op payload
	always_ff @(posedge clock)
	begin
		if (fetch)
			uop <= romWord;
	end

endmodule

// File: tests/ucodeControlTb.sv
`timescale 1ns/1ps
`include "ucodeControl_cfg.svh"

module ucodeControlTb;
	import ucodePkg::*;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 5;
	localparam int randomFlows = 8;
	// Bytes sent, CB second bytes included
	localparam int sentOps = 17 + randomFlows;

	// Expected words taken from the flow rules
	localparam uop_t nopEnd = '{endIncPc, nop, none};
	localparam uop_t ldBEnd = '{endFlow, readMem, b};
	localparam uop_t ldCEnd = '{endFlow, readMem, c};
	localparam uop_t ldAEnd = '{endFlow, readMem, a};
	localparam uop_t jumpEnd = '{endFlow, setPc, x16};
	localparam uop_t jrNzSkip = '{endIfZero, readMem, x8};
	localparam uop_t jrZSkip = '{endIfNotZero, readMem, x8};
	localparam uop_t arithEnd = '{endIncPc, storeX16, a};
	localparam uop_t pushEnd = '{endIncPc, setMemAddr, pc};
	localparam uop_t popEnd = '{endFlow, setMemAddr, pc};
	localparam uop_t bitEnd = '{endIncPc, bitTest, h};
	localparam uop_t rotEnd = '{endIncPc, rotLeft, c};
	localparam uop_t aluFirst = '{step, aluOneByte, a};

	logic                    clock = 1'b0;
	logic                    rst;
	logic                    opValid;
	logic [`UC_OPCODE_W-1:0] opcode;
	logic                    zeroFlag;
	logic                    uopValid;
	uop_t                    uop;
	logic                    pcInc;
	logic                    busy;
	logic                    flowDone;

	logic [3:0]  uopCount;
	logic [3:0]  pcIncCount;
	logic [3:0]  expLen;
	logic [3:0]  expPcInc;
	uop_t        expLast;
	logic        checkFirst;
	integer      seed = 40;
	logic [31:0] randWord;
	logic [7:0]  randOp;

	always #(clkPeriod / 2) clock = ~clock;

	ucodeControl dut0
	(
		.clock(clock),
		.rst(rst),
		.opValid(opValid),
		.opcode(opcode),
		.zeroFlag(zeroFlag),
		.uopValid(uopValid),
		.uop(uop),
		.pcInc(pcInc),
		.busy(busy),
		.flowDone(flowDone)
	);

	// Per-flow tallies, cleared once the flow has ended
	always @(posedge clock)
	begin
		if (rst || flowDone)
		begin
			uopCount <= '0;
			pcIncCount <= '0;
		end
		else
		begin
			uopCount <= uopCount + {3'b000, uopValid};
			pcIncCount <= pcIncCount + {3'b000, pcInc};
		end
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic valueError(input string name, input int expVal, input int actVal);
		abortRun($sformatf("** Error at %0t ns: %s expected %0h, actual %0h",
			$time, name, expVal, actVal));
	endtask

	// Rules of the bound protocol checker
	always @(posedge clock)
	begin
		if (dut0.chk0.ruleFailed)
			abortRun("A protocol rule of the top level was violated");
	end

	//////////////////////////////////////////////////////////////////////
	// Flow checks
	firstUopLatency: assert property (@(posedge clock) disable iff (rst)
		opValid |=> uopValid)
		else abortRun("No micro-op one cycle after the opcode strobe");

	flowLength: assert property (@(posedge clock) disable iff (rst)
		flowDone |-> (uopCount + 4'd1 == expLen))
		else valueError("uopCount", int'($sampled(expLen)), int'($sampled(uopCount)) + 1);

	pcIncTotal: assert property (@(posedge clock) disable iff (rst)
		flowDone |-> (pcIncCount + {3'b000, pcInc} == expPcInc))
		else valueError("pcInc", int'($sampled(expPcInc)),
			int'($sampled(pcIncCount)) + int'($sampled(pcInc)));

	lastWord: assert property (@(posedge clock) disable iff (rst)
		flowDone |-> (uop == expLast))
		else valueError("uop", int'($sampled(expLast)), int'($sampled(uop)));

	firstWord: assert property (@(posedge clock) disable iff (rst)
		(checkFirst && uopValid && uopCount == 4'd0) |-> (uop == aluFirst))
		else valueError("uop", int'(aluFirst), int'($sampled(uop)));

	// Busy drops once a flow is over
	busyClears: assert property (@(posedge clock) disable iff (rst)
		flowDone |=> !busy)
		else valueError("busy", 0, int'($sampled(busy)));

	// Held while the CB byte is awaited
	busyWhileCb: assert property (@(posedge clock) disable iff (rst)
		(uopValid && uop.action == fetchCb) |=> busy)
		else valueError("busy", 1, int'($sampled(busy)));

	function automatic logic isMapped(input logic [7:0] value);
		case (value)
			8'h00, 8'h06, 8'h0E, 8'h3E, 8'h18, 8'h20, 8'h28, 8'h80, 8'h90, 8'hC1, 8'hC5, 8'hCB:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Called right after a rising edge
	task automatic sendByte(input logic [7:0] value);
		opValid <= 1'b1;
		opcode <= value;
		@(posedge clock);
		opValid <= 1'b0;
	endtask

	task automatic runFlow(input logic [7:0] value, input logic zf, input logic [3:0] len,
		input logic [3:0] incs, input uop_t last);
		zeroFlag <= zf;
		expLen <= len;
		expPcInc <= incs;
		expLast <= last;
		sendByte(value);
		do @(posedge clock); while (!flowDone);
	endtask

	// Prefix, then the second byte once the fetchCb word is out
	task automatic runCbFlow(input logic [7:0] value, input uop_t last);
		expLen <= 4'd4;
		expPcInc <= 4'd2;
		expLast <= last;
		sendByte(8'hCB);
		do @(posedge clock); while (!(uopValid && uop.action == fetchCb));
		sendByte(value);
		do @(posedge clock); while (!flowDone);
	endtask

	initial
	begin
		#(clkPeriod * (resetCycles + 200 * sentOps));
		abortRun("Watchdog timeout, a flow never finished");
	end

	initial
	begin
		rst = 1'b1;
		opValid = 1'b0;
		opcode = '0;
		zeroFlag = 1'b0;
		expLen = '0;
		expPcInc = '0;
		expLast = nopEnd;
		checkFirst = 1'b0;
		repeat (resetCycles) @(posedge clock);
		rst <= 1'b0;
		repeat (3) @(posedge clock);

		runFlow(8'h00, 1'b0, 4'd1, 4'd1, nopEnd);
		runFlow(8'h06, 1'b0, 4'd3, 4'd2, ldBEnd);
		runFlow(8'h0E, 1'b0, 4'd3, 4'd2, ldCEnd);
		runFlow(8'h3E, 1'b0, 4'd3, 4'd2, ldAEnd);
		runFlow(8'h18, 1'b0, 4'd6, 4'd2, jumpEnd);

		// Conditional jumps both ways
		runFlow(8'h20, 1'b1, 4'd3, 4'd1, jrNzSkip);
		runFlow(8'h20, 1'b0, 4'd6, 4'd1, jumpEnd);
		runFlow(8'h28, 1'b0, 4'd3, 4'd1, jrZSkip);
		runFlow(8'h28, 1'b1, 4'd6, 4'd1, jumpEnd);

		runFlow(8'h80, 1'b0, 4'd3, 4'd1, arithEnd);
		runFlow(8'h90, 1'b0, 4'd3, 4'd1, arithEnd);
		runFlow(8'hC5, 1'b0, 4'd6, 4'd1, pushEnd);
		runFlow(8'hC1, 1'b0, 4'd6, 4'd1, popEnd);
		runCbFlow(8'h7C, bitEnd);
		runCbFlow(8'h11, rotEnd);

		// Unmapped bytes run the default flow
		checkFirst <= 1'b1;
		repeat (randomFlows)
		begin
			do
			begin
				randWord = $random(seed);
				randOp = randWord[7:0];
			end while (isMapped(randOp));
			runFlow(randOp, 1'b0, 4'd2, 4'd1, nopEnd);
		end

		repeat (2) @(posedge clock);
		$display("No errors");
		$finish;
	end

endmodule

// File: tests/ucodeControl_chk.sv
`timescale 1ns/1ps

module ucodeControlChk
(
	input logic clock,
	input logic rst,
	input logic opValid,
	input logic uopValid,
	input logic pcInc,
	input logic busy,
	input logic flowDone
);
	logic strobeSeen;
	logic ruleFailed = 1'b0;

	// Cleared by reset, set by the first opcode strobe
	always_ff @(posedge clock)
	begin
		if (rst)
			strobeSeen <= 1'b0;
		else if (opValid)
			strobeSeen <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Protocol rules of the top level
	doneWithUop: assert property (@(posedge clock) disable iff (rst)
		flowDone |-> uopValid)
		else
		begin
			ruleFailed = 1'b1;
			$error("flowDone raised without uopValid");
		end

	quietAfterReset: assert property (@(posedge clock) disable iff (rst)
		!strobeSeen |-> !(busy || uopValid || pcInc || flowDone))
		else
		begin
			ruleFailed = 1'b1;
			$error("Outputs active before the first opcode strobe");
		end

	uopInsideBusy: assert property (@(posedge clock) disable iff (rst)
		uopValid |-> busy)
		else
		begin
			ruleFailed = 1'b1;
			$error("uopValid raised while busy is low");
		end

endmodule

bind ucodeControl ucodeControlChk chk0
(
	.clock(clock),
	.rst(rst),
	.opValid(opValid),
	.uopValid(uopValid),
	.pcInc(pcInc),
	.busy(busy),
	.flowDone(flowDone)
);
